// ==== include/mult_macros.svh ====
`ifndef MULT_MACROS_SVH
`define MULT_MACROS_SVH

// operand widths
`define MULT_A_WIDTH    42
`define MULT_B_WIDTH    35

// full width of a times b
// the core returns only the low 70 bits of it
`define MULT_P_WIDTH    77

// enabled cycles from operands to product
`define MULT_LATENCY    6

// low split of both operands, also the cascade shift
`define MULT_LO_WIDTH   17

// apb bus
`define APB_ADDR_WIDTH  8
`define APB_DATA_WIDTH  32

`endif

// ==== hdl/mult_pkg.sv ====
`default_nettype none

`include "mult_macros.svh"

package mult_pkg;

  // result width kept by the core
  localparam int prod_width    = 2 * `MULT_B_WIDTH;
  localparam int prod_hi_width = prod_width - 2 * `MULT_LO_WIDTH;
  localparam int cascade_width = 48;

  typedef logic [`MULT_A_WIDTH-1:0] operand_a_t;
  typedef logic [`MULT_B_WIDTH-1:0] operand_b_t;
  typedef logic [prod_width-1:0]    product_t;
  typedef logic [cascade_width-1:0] cascade_t;

  // product as written by the slices
  typedef struct packed {
    logic [prod_hi_width-1:0]  hi;
    logic [`MULT_LO_WIDTH-1:0] mid;
    logic [`MULT_LO_WIDTH-1:0] lo;
  } product_seg_t;

  typedef union packed {
    product_t     flat;
    product_seg_t seg;
  } product_u;

endpackage

`default_nettype wire

// ==== hdl/apb_pkg.sv ====
`default_nettype none

`include "mult_macros.svh"

package apb_pkg;

  // register offsets
  typedef enum logic [`APB_ADDR_WIDTH-1:0] {
    reg_a_lo   = 8'h00,
    reg_a_hi   = 8'h04,
    reg_b_lo   = 8'h08,
    reg_b_hi   = 8'h0c,
    reg_ctrl   = 8'h10,
    reg_status = 8'h14,
    reg_p0     = 8'h18,
    reg_p1     = 8'h1c,
    reg_p2     = 8'h20
  } mult_reg_e;

  // status register
  localparam int status_busy_bit = 0;
  localparam int status_done_bit = 1;

  // control register, start reads back as zero
  localparam int ctrl_start_bit = 0;

endpackage

`default_nettype wire

// ==== hdl/mult_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface mult_if;

  import mult_pkg::*;

  logic       ena;
  operand_a_t dina;
  operand_b_t dinb;
  product_u   dout;

  // register block side
  modport ctrl (output ena, output dina, output dinb, input dout);

  // multiplier side
  modport core (input ena, input dina, input dinb, output dout);

endinterface

`default_nettype wire

// ==== hdl/shift_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module shift_reg #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 1
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             ena,
  input  logic [WIDTH-1:0] din,
  output logic [WIDTH-1:0] dout
);

  logic [DEPTH-1:0][WIDTH-1:0] pipe;

  always_ff @(posedge clk) begin
    if (reset) begin
      pipe <= '0;
    end else if (ena) begin
      pipe[0] <= din;
      for (int i = 1; i < DEPTH; i++) begin
        pipe[i] <= pipe[i-1];
      end
    end
  end

  assign dout = pipe[DEPTH-1];

endmodule

`default_nettype wire

// ==== hdl/dsp_slice.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mult_macros.svh"

module dsp_slice #(
  parameter int AREG       = 1,
  parameter int BREG       = 1,
  parameter bit B_CASCADE  = 1'b0,
  parameter bit PCIN_SHIFT = 1'b0,
  parameter bit USE_PCIN   = 1'b0
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              ena,
  input  logic [24:0]       a,
  input  logic [17:0]       b,
  input  logic [17:0]       bcin,
  input  mult_pkg::cascade_t pcin,
  output logic [17:0]       bcout,
  output mult_pkg::cascade_t p,
  output mult_pkg::cascade_t pcout
);

  import mult_pkg::*;

  logic [AREG-1:0][24:0] a_pipe;
  logic [BREG-1:0][17:0] b_pipe;
  logic [17:0]           b_src;
  logic [42:0]           m_reg;
  cascade_t              pc_term;
  cascade_t              p_reg;

  assign b_src = B_CASCADE ? bcin : b;

  // partial sum from the previous slice
  always_comb begin
    if (!USE_PCIN) begin
      pc_term = '0;
    end else if (PCIN_SHIFT) begin
      pc_term = pcin >> `MULT_LO_WIDTH;
    end else begin
      pc_term = pcin;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      a_pipe <= '0;
      b_pipe <= '0;
      m_reg  <= '0;
      p_reg  <= '0;
    end else if (ena) begin
      a_pipe[0] <= a;
      b_pipe[0] <= b_src;
      for (int i = 1; i < AREG; i++) begin
        a_pipe[i] <= a_pipe[i-1];
      end
      for (int i = 1; i < BREG; i++) begin
        b_pipe[i] <= b_pipe[i-1];
      end
      m_reg <= a_pipe[AREG-1] * b_pipe[BREG-1];
      p_reg <= {5'd0, m_reg} + pc_term;
    end
  end

  // cascade taps the first b stage so a deeper neighbour stays aligned
  assign bcout = b_pipe[0];
  assign p     = p_reg;
  assign pcout = p_reg;

endmodule

`default_nettype wire

// ==== hdl/math_mult_35.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mult_macros.svh"

module math_mult_35 (
  input logic  clk,
  input logic  reset,
  mult_if.core bus
);

  import mult_pkg::*;

  localparam int lo_w   = `MULT_LO_WIDTH;
  localparam int a_hi_w = `MULT_A_WIDTH - `MULT_LO_WIDTH;
  localparam int b_hi_w = `MULT_B_WIDTH - `MULT_LO_WIDTH;

  logic [b_hi_w+lo_w-1:0] s2_in;   // {b high, a low}, delay 1
  logic [lo_w-1:0]        s2_a;
  logic [b_hi_w-1:0]      s2_b;
  logic [a_hi_w-1:0]      s3_a;    // a high, delay 2

  logic [17:0] bc_01;              // b cascade, slice 0 -> 1
  logic [17:0] bc_23;              // b cascade, slice 2 -> 3
  cascade_t    pc_01;
  cascade_t    pc_12;
  cascade_t    pc_23;

  cascade_t    p0;
  cascade_t    p2;
  cascade_t    p3;

  logic [lo_w-1:0] lo_q;
  logic [lo_w-1:0] mid_q;

  //////////////////////////////////////////////////
  // input alignment

  shift_reg #(.WIDTH(b_hi_w + lo_w), .DEPTH(1)) u_dly_s2 (
    .clk   (clk),
    .reset (reset),
    .ena   (bus.ena),
    .din   ({bus.dinb[`MULT_B_WIDTH-1:lo_w], bus.dina[lo_w-1:0]}),
    .dout  (s2_in)
  );

  assign s2_a = s2_in[lo_w-1:0];
  assign s2_b = s2_in[b_hi_w+lo_w-1:lo_w];

  shift_reg #(.WIDTH(a_hi_w), .DEPTH(2)) u_dly_s3 (
    .clk   (clk),
    .reset (reset),
    .ena   (bus.ena),
    .din   (bus.dina[`MULT_A_WIDTH-1:lo_w]),
    .dout  (s3_a)
  );

  //////////////////////////////////////////////////
  // slices

  // a low times b low, product bits 16:0
  dsp_slice #(.AREG(1), .BREG(1)) u_slice_0 (
    .clk (clk), .reset (reset), .ena (bus.ena),
    .a     ({{(25-lo_w){1'b0}}, bus.dina[lo_w-1:0]}),
    .b     ({{(18-lo_w){1'b0}}, bus.dinb[lo_w-1:0]}),
    .bcin  (18'd0),
    .pcin  ('0),
    .bcout (bc_01),
    .p     (p0),
    .pcout (pc_01)
  );

  // a high times b low
  dsp_slice #(.AREG(2), .BREG(1), .B_CASCADE(1'b1), .PCIN_SHIFT(1'b1), .USE_PCIN(1'b1))
  u_slice_1 (
    .clk (clk), .reset (reset), .ena (bus.ena),
    .a     (bus.dina[`MULT_A_WIDTH-1:lo_w]),
    .b     (18'd0),
    .bcin  (bc_01),
    .pcin  (pc_01),
    .bcout (),
    .p     (),
    .pcout (pc_12)
  );

  // a low times b high, product bits 33:17
  dsp_slice #(.AREG(2), .BREG(2), .USE_PCIN(1'b1)) u_slice_2 (
    .clk (clk), .reset (reset), .ena (bus.ena),
    .a     ({{(25-lo_w){1'b0}}, s2_a}),
    .b     (s2_b),
    .bcin  (18'd0),
    .pcin  (pc_12),
    .bcout (bc_23),
    .p     (p2),
    .pcout (pc_23)
  );

  // a high times b high, product bits 69:34
  dsp_slice #(.AREG(2), .BREG(2), .B_CASCADE(1'b1), .PCIN_SHIFT(1'b1), .USE_PCIN(1'b1))
  u_slice_3 (
    .clk (clk), .reset (reset), .ena (bus.ena),
    .a     (s3_a),
    .b     (18'd0),
    .bcin  (bc_23),
    .pcin  (pc_23),
    .bcout (),
    .p     (p3),
    .pcout ()
  );

  //////////////////////////////////////////////////
  // output alignment

  shift_reg #(.WIDTH(lo_w), .DEPTH(3)) u_dly_lo (
    .clk (clk), .reset (reset), .ena (bus.ena),
    .din (p0[lo_w-1:0]), .dout (lo_q)
  );

  shift_reg #(.WIDTH(lo_w), .DEPTH(1)) u_dly_mid (
    .clk (clk), .reset (reset), .ena (bus.ena),
    .din (p2[lo_w-1:0]), .dout (mid_q)
  );

  assign bus.dout.seg = '{hi: p3[prod_hi_width-1:0], mid: mid_q, lo: lo_q};

endmodule

`default_nettype wire

// ==== hdl/mult_apb_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mult_macros.svh"

module mult_apb_regs (
  input  logic                       clk,
  input  logic                       reset,
  // apb slave
  input  logic [`APB_ADDR_WIDTH-1:0] paddr,
  input  logic                       psel,
  input  logic                       penable,
  input  logic                       pwrite,
  input  logic [`APB_DATA_WIDTH-1:0] pwdata,
  output logic [`APB_DATA_WIDTH-1:0] prdata,
  output logic                       pready,
  output logic                       pslverr,
  // multiplier core
  mult_if.ctrl                       bus
);

  import mult_pkg::*;
  import apb_pkg::*;

  localparam int dw        = `APB_DATA_WIDTH;
  localparam int cnt_width = $clog2(`MULT_LATENCY + 1);

  operand_a_t           a_reg;
  operand_b_t           b_reg;
  product_t             prod_reg;
  logic                 busy;
  logic                 done;
  logic [cnt_width-1:0] lat_cnt;
  logic                 lat_end;

  logic                 access;
  logic                 mapped;
  logic                 read_only;
  logic                 wr_en;
  logic                 start;
  logic [dw-1:0]        rd_data;

  //////////////////////////////////////////////////
  // register decode

  always_comb begin
    mapped    = 1'b1;
    read_only = 1'b0;
    rd_data   = '0;
    case (paddr)
      reg_a_lo: rd_data = a_reg[dw-1:0];
      reg_a_hi: rd_data = dw'(a_reg[`MULT_A_WIDTH-1:dw]);
      reg_b_lo: rd_data = b_reg[dw-1:0];
      reg_b_hi: rd_data = dw'(b_reg[`MULT_B_WIDTH-1:dw]);
      // start is a pulse, nothing to read
      reg_ctrl: rd_data = '0;
      reg_status: begin
        read_only                = 1'b1;
        rd_data[status_busy_bit] = busy;
        rd_data[status_done_bit] = done;
      end
      reg_p0: begin
        read_only = 1'b1;
        rd_data   = prod_reg[dw-1:0];
      end
      reg_p1: begin
        read_only = 1'b1;
        rd_data   = prod_reg[2*dw-1:dw];
      end
      reg_p2: begin
        read_only = 1'b1;
        rd_data   = dw'(prod_reg[prod_width-1:2*dw]);
      end
      default: mapped = 1'b0;
    endcase
  end

  assign access  = psel & penable;
  assign pready  = 1'b1;
  assign pslverr = access & (~mapped | (pwrite & (read_only | busy)));
  assign prdata  = (access & ~pwrite) ? rd_data : '0;

  // operands and ctrl are locked while a job runs
  assign wr_en = access & pwrite & mapped & ~read_only & ~busy;
  assign start = wr_en & (paddr == reg_ctrl) & pwdata[ctrl_start_bit];

  //////////////////////////////////////////////////
  // operand registers

  always_ff @(posedge clk) begin
    if (reset) begin
      a_reg <= '0;
      b_reg <= '0;
    end else if (wr_en) begin
      case (paddr)
        reg_a_lo: a_reg[dw-1:0]               <= pwdata;
        reg_a_hi: a_reg[`MULT_A_WIDTH-1:dw]   <= pwdata[`MULT_A_WIDTH-dw-1:0];
        reg_b_lo: b_reg[dw-1:0]               <= pwdata;
        reg_b_hi: b_reg[`MULT_B_WIDTH-1:dw]   <= pwdata[`MULT_B_WIDTH-dw-1:0];
        default: ;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // job control

  assign lat_end = (lat_cnt == cnt_width'(`MULT_LATENCY));

  always_ff @(posedge clk) begin
    if (reset) begin
      busy     <= 1'b0;
      done     <= 1'b0;
      lat_cnt  <= '0;
      prod_reg <= '0;
    end else if (start) begin
      busy    <= 1'b1;
      done    <= 1'b0;
      lat_cnt <= '0;
    end else if (busy) begin
      if (lat_end) begin
        // pipeline has run its full latency on stable operands
        prod_reg <= bus.dout.flat;
        busy     <= 1'b0;
        done     <= 1'b1;
      end else begin
        lat_cnt <= lat_cnt + 1'b1;
      end
    end
  end

  assign bus.ena  = busy & ~lat_end;
  assign bus.dina = a_reg;
  assign bus.dinb = b_reg;

endmodule

`default_nettype wire

// ==== hdl/mult_apb_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mult_macros.svh"

module mult_apb_top (
  input  logic                       clk,
  input  logic                       reset,
  input  logic [`APB_ADDR_WIDTH-1:0] paddr,
  input  logic                       psel,
  input  logic                       penable,
  input  logic                       pwrite,
  input  logic [`APB_DATA_WIDTH-1:0] pwdata,
  output logic [`APB_DATA_WIDTH-1:0] prdata,
  output logic                       pready,
  output logic                       pslverr
);

  // operands, enable and product between regs and core
  mult_if mult_bus ();

  mult_apb_regs u_regs (
    .clk     (clk),
    .reset   (reset),
    .paddr   (paddr),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .bus     (mult_bus)
  );

  math_mult_35 u_core (
    .clk   (clk),
    .reset (reset),
    .bus   (mult_bus)
  );

endmodule

`default_nettype wire

// ==== testbench/tb_mult_apb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mult_macros.svh"

module tb_mult_apb;

  import mult_pkg::*;
  import apb_pkg::*;

  localparam int aw             = `APB_ADDR_WIDTH;
  localparam int dw             = `APB_DATA_WIDTH;
  localparam int num_patterns   = 20;
  localparam int num_random     = 40;
  localparam int job_margin     = 10;
  localparam int max_polls      = 50;
  localparam int timeout_cycles = 200 * (num_patterns + num_random + job_margin);

  logic          clk;
  logic          reset;
  logic [aw-1:0] paddr;
  logic          psel;
  logic          penable;
  logic          pwrite;
  logic [dw-1:0] pwdata;
  logic [dw-1:0] prdata;
  logic          pready;
  logic          pslverr;

  // three words per record: a, b, expected product
  product_t   patterns [0:3*num_patterns-1];
  integer     seed;
  operand_a_t a;
  operand_b_t b;
  product_t   expected;
  product_t   result;
  logic [dw-1:0] rdata;
  logic          err;

  mult_apb_top uut (
    .clk     (clk),
    .reset   (reset),
    .paddr   (paddr),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin
    repeat (timeout_cycles) @(posedge clk);
    $display("simulation timed out after %0d cycles", timeout_cycles);
    $display("TEST FAIL");
    $fatal(1, "watchdog expired");
  end

  //////////////////////////////////////////////////
  // helpers

  task automatic check_value(input string name, input logic [79:0] exp_val,
                             input logic [79:0] act_val);
    if (exp_val !== act_val) begin
      $display("CHECK FAILED: %s expected 0x%0h actual 0x%0h", name, exp_val, act_val);
      $display("TEST FAIL");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  // low 70 bits of the full 77 bit product
  function automatic product_t full_product(input operand_a_t op_a, input operand_b_t op_b);
    logic [`MULT_P_WIDTH-1:0] full;
    full = `MULT_P_WIDTH'(op_a) * `MULT_P_WIDTH'(op_b);
    return full[prod_width-1:0];
  endfunction

  // entered and left 1 ns after a rising edge
  task automatic write_reg(input logic [aw-1:0] addr, input logic [dw-1:0] data,
                           output logic slverr);
    paddr   = addr;
    pwdata  = data;
    pwrite  = 1'b1;
    psel    = 1'b1;
    penable = 1'b0;
    @(posedge clk);
    #1;
    penable = 1'b1;
    @(negedge clk);
    slverr = pslverr;
    @(posedge clk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic read_reg(input logic [aw-1:0] addr, output logic [dw-1:0] data,
                          output logic slverr);
    paddr   = addr;
    pwrite  = 1'b0;
    psel    = 1'b1;
    penable = 1'b0;
    @(posedge clk);
    #1;
    penable = 1'b1;
    @(negedge clk);
    data   = prdata;
    slverr = pslverr;
    @(posedge clk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic write_ok(input string name, input logic [aw-1:0] addr,
                          input logic [dw-1:0] data);
    logic slverr;
    write_reg(addr, data, slverr);
    check_value($sformatf("%s pslverr", name), 80'(1'b0), 80'(slverr));
  endtask

  task automatic write_rejected(input string name, input logic [aw-1:0] addr,
                                input logic [dw-1:0] data);
    logic slverr;
    write_reg(addr, data, slverr);
    check_value($sformatf("%s pslverr", name), 80'(1'b1), 80'(slverr));
  endtask

  task automatic read_expect(input string name, input logic [aw-1:0] addr,
                             input logic [dw-1:0] exp_data);
    logic [dw-1:0] data;
    logic          slverr;
    read_reg(addr, data, slverr);
    check_value($sformatf("%s pslverr", name), 80'(1'b0), 80'(slverr));
    check_value(name, 80'(exp_data), 80'(data));
  endtask

  task automatic load_operands(input operand_a_t op_a, input operand_b_t op_b);
    write_ok("write a_lo", reg_a_lo, op_a[31:0]);
    write_ok("write a_hi", reg_a_hi, {22'd0, op_a[41:32]});
    write_ok("write b_lo", reg_b_lo, op_b[31:0]);
    write_ok("write b_hi", reg_b_hi, {29'd0, op_b[34:32]});
  endtask

  // poll status, busy without done until the job ends
  task automatic wait_done(input string name);
    logic [dw-1:0] status;
    logic          slverr;
    logic          finished;
    finished = 1'b0;
    status   = '0;
    for (int i = 0; i < max_polls && !finished; i++) begin
      read_reg(reg_status, status, slverr);
      check_value($sformatf("%s status pslverr", name), 80'(1'b0), 80'(slverr));
      finished = status[status_done_bit];
      if (!finished) begin
        check_value($sformatf("%s status while busy", name), 80'h1, 80'(status));
      end
    end
    if (!finished) begin
      $display("multiplier never finished for %s after %0d status polls", name, max_polls);
      $display("TEST FAIL");
      $fatal(1, "job did not complete");
    end
    check_value($sformatf("%s status after job", name), 80'h2, 80'(status));
  endtask

  task automatic read_product(input string name, output product_t prod);
    logic [dw-1:0] w0;
    logic [dw-1:0] w1;
    logic [dw-1:0] w2;
    logic          slverr;
    read_reg(reg_p0, w0, slverr);
    check_value($sformatf("%s p0 pslverr", name), 80'(1'b0), 80'(slverr));
    read_reg(reg_p1, w1, slverr);
    check_value($sformatf("%s p1 pslverr", name), 80'(1'b0), 80'(slverr));
    read_reg(reg_p2, w2, slverr);
    check_value($sformatf("%s p2 pslverr", name), 80'(1'b0), 80'(slverr));
    check_value($sformatf("%s p2 unused bits", name), 80'd0, 80'(w2[31:6]));
    prod = {w2[5:0], w1, w0};
  endtask

  task automatic run_job(input string name, input operand_a_t op_a, input operand_b_t op_b,
                         input product_t exp_prod);
    product_t prod;
    load_operands(op_a, op_b);
    write_ok($sformatf("%s start", name), reg_ctrl, 32'h1);
    wait_done(name);
    read_product(name, prod);
    check_value(name, 80'(exp_prod), 80'(prod));
  endtask

  //////////////////////////////////////////////////
  // main sequence

  initial begin
    reset   = 1'b1;
    paddr   = '0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    pwdata  = '0;
    seed    = 32'h186c;
    repeat (4) @(posedge clk);
    #1;
    reset = 1'b0;

    // reset state
    check_value("pready", 80'(1'b1), 80'(pready));
    read_expect("reset status", reg_status, 32'h0);
    read_expect("reset p0", reg_p0, 32'h0);
    read_expect("reset p1", reg_p1, 32'h0);
    read_expect("reset p2", reg_p2, 32'h0);

    // operand readback, high words masked
    write_ok("readback a_lo", reg_a_lo, 32'hdeadbeef);
    write_ok("readback a_hi", reg_a_hi, 32'hffffffff);
    write_ok("readback b_lo", reg_b_lo, 32'h89abcdef);
    write_ok("readback b_hi", reg_b_hi, 32'hffffffff);
    read_expect("read a_lo", reg_a_lo, 32'hdeadbeef);
    read_expect("read a_hi", reg_a_hi, 32'h000003ff);
    read_expect("read b_lo", reg_b_lo, 32'h89abcdef);
    read_expect("read b_hi", reg_b_hi, 32'h00000007);

    // error responses
    write_rejected("unmapped write", 8'h24, 32'h1);
    read_reg(8'h3c, rdata, err);
    check_value("unmapped read pslverr", 80'(1'b1), 80'(err));

    a = 42'h2aa55551234;
    b = 35'h50f0ff0f0;
    run_job("first job", a, b, full_product(a, b));
    write_rejected("status write", reg_status, 32'h0);
    read_expect("status kept done", reg_status, 32'h2);
    write_rejected("p0 write", reg_p0, 32'hffffffff);
    read_product("after p0 write", result);
    check_value("product kept", 80'(full_product(a, b)), 80'(result));

    // writes while the job runs are refused
    a = 42'h1ff0001ffff;
    b = 35'h3fffe0001;
    load_operands(a, b);
    write_ok("busy job start", reg_ctrl, 32'h1);
    read_expect("status while busy", reg_status, 32'h1);
    write_rejected("a_lo write while busy", reg_a_lo, 32'h12345678);
    write_rejected("start while busy", reg_ctrl, 32'h1);
    wait_done("busy job");
    read_product("busy job", result);
    check_value("busy job product", 80'(full_product(a, b)), 80'(result));
    read_expect("a_lo kept", reg_a_lo, a[31:0]);

    // pattern file
    $readmemh("testbench/mult_patterns.txt", patterns);
    for (int i = 0; i < num_patterns; i++) begin
      a        = operand_a_t'(patterns[3*i]);
      b        = operand_b_t'(patterns[3*i+1]);
      expected = patterns[3*i+2];
      check_value($sformatf("pattern %0d file vs model", i),
                  80'(full_product(a, b)), 80'(expected));
      run_job($sformatf("pattern %0d", i), a, b, expected);
    end

    // random operands
    for (int i = 0; i < num_random; i++) begin
      a = operand_a_t'({$random(seed), $random(seed)});
      b = operand_b_t'({$random(seed), $random(seed)});
      run_job($sformatf("random %0d", i), a, b, full_product(a, b));
    end

    $display("TEST PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== testbench/mult_patterns.txt ====
// columns: operand a (42 bits), operand b (35 bits), expected product (low 70 bits)
// one record per line, all values hexadecimal
0 0 0
0 7FFFFFFFF 0
3FFFFFFFFFF 0 0
1 1 1
1 7FFFFFFFF 7FFFFFFFF
3FFFFFFFFFF 1 3FFFFFFFFFF
3FFFFFFFFFF 7FFFFFFFF 3FFFFFFBF800000001
1FFFF 1FFFF 3FFFC0001
20000 20000 400000000
3FFFFFFFFFF 1FFFF 7FFFBFFFFFE0001
1FFFF 7FFFFFFFF FFFF7FFFE0001
3FFFFFE0000 7FFFE0000 3FF7F0000400000000
15555555555 2 2AAAAAAAAAA
12345678 10000 123456780000
100000000 400000000 40000000000000000
20000000000 400000000 0
1FFFF 20000 3FFFE0000
3FFFFFFFFFF 20000 7FFFFFFFFFE0000
3 5 F
FFFFFFFF FFFFFFFF FFFFFFFE00000001

// ==== sources.f ====
+incdir+include
hdl/mult_pkg.sv
hdl/apb_pkg.sv
hdl/mult_if.sv
hdl/shift_reg.sv
hdl/dsp_slice.sv
hdl/math_mult_35.sv
hdl/mult_apb_regs.sv
hdl/mult_apb_top.sv
testbench/tb_mult_apb.sv

// ==== Makefile ====
# Verilator build and run of the APB multiplier testbench

VERILATOR ?= verilator
TOP       ?= tb_mult_apb
FILELIST  ?= sources.f
BUILD_DIR ?= build
VFLAGS    ?= -Wno-fatal

# every source named in the file list, plus the included headers
SRCS ?= $(filter-out +%,$(shell cat $(FILELIST)))
HDRS ?= $(wildcard include/*.svh)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) --binary --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST) $(VFLAGS)

# exit status of the simulator is the test result
run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(BUILD_DIR)
